//--- include/tb_ref_model.svh
/*
 * reference model for the testbench, include after both packages
 * ref_vote applies the vote, compare, bypass and blame rules of the voter
 */

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// 32 bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

function automatic ft_alu_pkg::alu_rsp_t ref_alu(input ft_alu_pkg::alu_req_t req);
	ft_alu_pkg::alu_rsp_t rsp;
	rsp = '0;
	case (req.op)
		ft_alu_pkg::ALU_ADD: rsp.result = req.a + req.b;
		ft_alu_pkg::ALU_SUB: rsp.result = req.a - req.b;
		ft_alu_pkg::ALU_AND: rsp.result = req.a & req.b;
		ft_alu_pkg::ALU_OR:  rsp.result = req.a | req.b;
		ft_alu_pkg::ALU_XOR: rsp.result = req.a ^ req.b;
		ft_alu_pkg::ALU_SLL: rsp.result = req.a << req.b[4:0];
		ft_alu_pkg::ALU_SRL: rsp.result = req.a >> req.b[4:0];
		ft_alu_pkg::ALU_SRA: rsp.result = $signed(req.a) >>> req.b[4:0];
		ft_alu_pkg::ALU_SLT: rsp.cmp = ($signed(req.a) < $signed(req.b));
		ft_alu_pkg::ALU_SLTU: rsp.cmp = (req.a < req.b);
		default: rsp.result = '0;
	endcase
	if (req.op == ft_alu_pkg::ALU_SLT || req.op == ft_alu_pkg::ALU_SLTU) begin
		rsp.result = {31'b0, rsp.cmp};
	end
	return rsp;
endfunction

// expected voter outputs for four replica responses
function automatic void ref_vote(
	input  ft_alu_pkg::alu_rsp_t [3:0] rsp,
	input  ft_cfg_pkg::ft_cfg_t        cfg,
	output ft_alu_pkg::alu_rsp_t       out,
	output logic                       det,
	output logic                       corr,
	output ft_cfg_pkg::replica_mask_t  blame
);
	ft_alu_pkg::alu_rsp_t s [3];
	logic [2:0] bad;
	for (int k = 0; k < 3; k++) s[k] = cfg.slot_sel[k] ? rsp[3] : rsp[k];
	out  = s[0];
	bad  = '0;
	if (cfg.only_two) bad = (s[0] != s[1]) ? 3'b011 : 3'b000;
	else if (s[0] == s[1] && s[0] == s[2]) bad = '0;
	else if (s[0] == s[1]) bad = 3'b100;
	else if (s[0] == s[2]) bad = 3'b010;
	else if (s[1] == s[2]) begin
		bad = 3'b001;
		out = s[1];
	end else bad = 3'b111;
	det  = |bad;
	corr = !cfg.only_two && det && (bad != 3'b111);
	if (cfg.bypass != 2'd0) out = s[cfg.bypass - 1];
	blame = '0;
	for (int k = 0; k < 3; k++) if (bad[k]) blame[cfg.slot_sel[k] ? 3 : k] = 1'b1;
endfunction

`endif

//--- dv/tb_ft_alu.sv
/*
 * testbench for ft_alu_top, random requests from a 32 bit fibonacci LFSR
 * expected counts and flags are tracked from the reference vote model
 */

`timescale 1ns/1ps
`default_nettype none

module tb_ft_alu;

	localparam int FAULT_THRESHOLD = 4;
	localparam int N_AGREE  = 40;
	localparam int N_FAULT  = 6;
	localparam int OVERHEAD = 40;	// csr traffic and drain per test
	localparam int RUN_CYCLES = 5 + N_AGREE + 6 * N_FAULT + FAULT_THRESHOLD + 6 * OVERHEAD;
	localparam int CYCLE_LIMIT = 2 * RUN_CYCLES;

	typedef struct packed {
		ft_alu_pkg::data_t result;
		logic              cmp;
		logic              det;
		logic              corr;
	} exp_t;

	logic                                               clk;
	logic                                               arst_n;
	logic                                               op_valid;
	ft_alu_pkg::alu_req_t [ft_alu_pkg::NUM_REPLICAS-1:0] req;
	logic                                               rsp_valid;
	ft_alu_pkg::data_t                                  result;
	logic                                               cmp;
	logic                                               err_det;
	logic                                               err_corr;
	ft_cfg_pkg::replica_mask_t                          permanent;
	logic                                               csr_we;
	ft_cfg_pkg::csr_addr_t                              csr_addr;
	ft_alu_pkg::data_t                                  csr_wdata;
	ft_alu_pkg::data_t                                  csr_rdata;

	exp_t                 exp_q [$];
	exp_t                 exp_item;
	ft_cfg_pkg::ft_cfg_t  cur_cfg;
	ft_cfg_pkg::err_cnt_t exp_cnt [ft_alu_pkg::NUM_REPLICAS];
	logic [31:0]          lfsr_state;
	string                test_name;
	int                   checks;
	int                   errors;
	int                   tests_run;
	int                   t_checks;
	int                   t_errors;
	int                   cycles;

	`include "tb_ref_model.svh"

	ft_alu_top #(
		.FAULT_THRESHOLD (FAULT_THRESHOLD)
	) i_ft_alu_top (
		.clk             (clk),
		.arst_n_i        (arst_n),
		.op_valid_i      (op_valid),
		.req_i           (req),
		.rsp_valid_o     (rsp_valid),
		.result_o        (result),
		.cmp_o           (cmp),
		.err_detected_o  (err_det),
		.err_corrected_o (err_corr),
		.permanent_o     (permanent),
		.csr_we_i        (csr_we),
		.csr_addr_i      (csr_addr),
		.csr_wdata_i     (csr_wdata),
		.csr_rdata_o     (csr_rdata)
	);

	always #50 clk = ~clk;	// 100 ns period

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run exceeded %0d cycles, responses still missing", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// response comparison, outputs are stable at the falling edge
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (arst_n && rsp_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("%s: response valid with no request outstanding", test_name);
			end else begin
				exp_item = exp_q.pop_front();
				checks++;
				if (result !== exp_item.result) begin
					errors++;
					$display("FAIL %s: result expected %h actual %h", test_name,
						exp_item.result, result);
				end
				if (cmp !== exp_item.cmp) begin
					errors++;
					$display("FAIL %s: cmp expected %b actual %b", test_name, exp_item.cmp, cmp);
				end
				if ({err_det, err_corr} !== {exp_item.det, exp_item.corr}) begin
					errors++;
					$display("FAIL %s: det/corr expected %b%b actual %b%b", test_name,
						exp_item.det, exp_item.corr, err_det, err_corr);
				end
			end
		end
	end

	function logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);	// one step per bit
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// full op set, or only ops where any change of a shows in the result
	function ft_alu_pkg::alu_req_t rand_req(input logic any_op);
		ft_alu_pkg::alu_req_t r;
		logic [3:0]           opc;
		if (any_op) opc = 4'(take_bits(4) % 10);
		else opc = (take_bits(2) % 3 == 0) ? 4'd0 : ((take_bits(1) == 0) ? 4'd1 : 4'd4);
		r.op = ft_alu_pkg::alu_op_e'(opc);
		r.a  = take_bits(32);
		r.b  = take_bits(32);
		return r;
	endfunction

	function ft_cfg_pkg::replica_mask_t perm_model();
		ft_cfg_pkg::replica_mask_t m;
		for (int r = 0; r < ft_alu_pkg::NUM_REPLICAS; r++) begin
			m[r] = (exp_cnt[r] >= FAULT_THRESHOLD);
		end
		return m;
	endfunction

	// bad_rep < 0 sends the same request to every replica
	task automatic send_op(input ft_alu_pkg::alu_req_t base, input int bad_rep);
		ft_alu_pkg::alu_req_t [3:0] req_d;
		ft_alu_pkg::alu_rsp_t [3:0] rr;
		ft_alu_pkg::alu_rsp_t       o;
		ft_cfg_pkg::replica_mask_t  blame;
		logic                       det;
		logic                       corr;
		for (int r = 0; r < 4; r++) begin
			req_d[r] = base;
			if (r == bad_rep) req_d[r].a = base.a ^ (32'h1 << take_bits(5));
			rr[r] = ref_alu(req_d[r]);
		end
		ref_vote(rr, cur_cfg, o, det, corr, blame);
		for (int r = 0; r < 4; r++) begin
			if (blame[r] && exp_cnt[r] != 8'hff) exp_cnt[r]++;
		end
		@(negedge clk);
		op_valid = 1'b1;
		req      = req_d;
		exp_q.push_back({o.result, o.cmp, det, corr});
	endtask

	task automatic drain();
		@(negedge clk);
		op_valid = 1'b0;
		while (exp_q.size() != 0) @(negedge clk);
		@(negedge clk);	// counter update edge has passed
	endtask

	task automatic csr_write(input ft_cfg_pkg::csr_addr_t a, input ft_alu_pkg::data_t d);
		@(negedge clk);
		csr_we    = 1'b1;
		csr_addr  = a;
		csr_wdata = d;
		@(negedge clk);
		csr_we = 1'b0;
		if (a == ft_cfg_pkg::CSR_CFG) begin
			cur_cfg = d[5:0];
		end else if (a >= ft_cfg_pkg::CSR_CNT0 && a <= ft_cfg_pkg::CSR_CNT3) begin
			exp_cnt[a - 1] = d[7:0];
		end
	endtask

	task automatic csr_check(input ft_cfg_pkg::csr_addr_t a, input ft_alu_pkg::data_t exp_d);
		@(negedge clk);
		csr_we   = 1'b0;
		csr_addr = a;
		@(negedge clk);
		checks++;
		if (csr_rdata !== exp_d) begin
			errors++;
			$display("FAIL %s: csr %0d expected %h actual %h", test_name, a, exp_d, csr_rdata);
		end
	endtask

	task automatic check_counts();
		for (int r = 0; r < 4; r++) begin
			csr_check(ft_cfg_pkg::csr_addr_t'(ft_cfg_pkg::CSR_CNT0 + r), {24'b0, exp_cnt[r]});
		end
		csr_check(ft_cfg_pkg::CSR_STATUS, {28'b0, perm_model()});
		checks++;
		if (permanent !== perm_model()) begin
			errors++;
			$display("FAIL %s: permanent expected %b actual %b", test_name,
				perm_model(), permanent);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		t_checks  = checks;
		t_errors  = errors;
	endtask

	task automatic end_test();
		tests_run++;
		$display("%s: %0d checks, %0d errors", test_name, checks - t_checks, errors - t_errors);
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		op_valid = 1'b0;
		req = '0;
		csr_we = 1'b0;
		csr_addr = '0;
		csr_wdata = '0;
		cur_cfg = '0;
		lfsr_state = 32'h23d;
		checks = 0;
		errors = 0;
		tests_run = 0;
		cycles = 0;
		for (int r = 0; r < 4; r++) exp_cnt[r] = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		start_test("agreement");
		if (rsp_valid !== 1'b0) begin
			errors++;
			$display("%s: response valid high straight after reset", test_name);
		end
		for (int i = 0; i < N_AGREE; i++) send_op(rand_req(1'b1), -1);
		drain();
		check_counts();
		end_test();

		start_test("single_fault");
		for (int i = 0; i < N_FAULT; i++) send_op(rand_req(1'b0), 1);
		drain();
		check_counts();
		end_test();

		start_test("spare_mapping");
		csr_write(ft_cfg_pkg::CSR_CFG, 32'h10);	// slot 1 takes replica 3
		for (int i = 0; i < N_FAULT; i++) send_op(rand_req(1'b0), 1);
		for (int i = 0; i < N_FAULT; i++) send_op(rand_req(1'b0), 3);
		drain();
		check_counts();
		end_test();

		start_test("two_replica");
		csr_write(ft_cfg_pkg::CSR_CFG, 32'h04);
		for (int i = 0; i < N_FAULT; i++) send_op(rand_req(1'b0), 0);
		for (int i = 0; i < N_FAULT; i++) send_op(rand_req(1'b0), 1);
		drain();
		check_counts();
		end_test();

		start_test("bypass");
		csr_write(ft_cfg_pkg::CSR_CFG, 32'h02);	// slot 1 direct
		for (int i = 0; i < N_FAULT; i++) send_op(rand_req(1'b0), 1);
		drain();
		csr_check(ft_cfg_pkg::CSR_CFG, 32'h02);
		check_counts();
		end_test();

		start_test("permanent");
		csr_write(ft_cfg_pkg::CSR_CFG, 32'h00);
		csr_write(ft_cfg_pkg::CSR_CNT2, 32'h00);
		for (int i = 0; i < FAULT_THRESHOLD - 1; i++) send_op(rand_req(1'b0), 2);
		drain();
		check_counts();	// one short of the threshold
		send_op(rand_req(1'b0), 2);
		drain();
		check_counts();
		checks++;
		if (permanent[2] !== 1'b1) begin
			errors++;
			$display("FAIL %s: permanent[2] expected 1 actual %b", test_name, permanent[2]);
		end
		csr_write(ft_cfg_pkg::CSR_CNT2, 32'h00);
		check_counts();
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/alu_core.sv
/*
 * single ALU replica, result and flag registered on valid_i
 * the registered response holds until the next valid request
 */

`timescale 1ns/1ps
`default_nettype none

module alu_core (
	input  wire logic                 clk,
	input  wire logic                 arst_n_i,
	input  wire logic                 valid_i,
	input  ft_alu_pkg::alu_req_t      req_i,
	output ft_alu_pkg::alu_rsp_t      rsp_o
);

	ft_alu_pkg::alu_rsp_t rsp_d;
	logic [4:0]           shamt;
	logic                 lt_s;
	logic                 lt_u;

	assign shamt = req_i.b[4:0];	// rv32 shift amount
	assign lt_s  = $signed(req_i.a) < $signed(req_i.b);
	assign lt_u  = req_i.a < req_i.b;

	always_comb begin
		rsp_d.cmp = 1'b0;
		case (req_i.op)
			ft_alu_pkg::ALU_ADD:  rsp_d.result = req_i.a + req_i.b;
			ft_alu_pkg::ALU_SUB:  rsp_d.result = req_i.a - req_i.b;
			ft_alu_pkg::ALU_AND:  rsp_d.result = req_i.a & req_i.b;
			ft_alu_pkg::ALU_OR:   rsp_d.result = req_i.a | req_i.b;
			ft_alu_pkg::ALU_XOR:  rsp_d.result = req_i.a ^ req_i.b;
			ft_alu_pkg::ALU_SLL:  rsp_d.result = req_i.a << shamt;
			ft_alu_pkg::ALU_SRL:  rsp_d.result = req_i.a >> shamt;
			ft_alu_pkg::ALU_SRA:  rsp_d.result = $signed(req_i.a) >>> shamt;
			ft_alu_pkg::ALU_SLT: begin
				rsp_d.result = {31'b0, lt_s};
				rsp_d.cmp    = lt_s;
			end
			ft_alu_pkg::ALU_SLTU: begin
				rsp_d.result = {31'b0, lt_u};
				rsp_d.cmp    = lt_u;
			end
			default: rsp_d.result = '0;	// undefined codes give zero
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rsp_o <= '0;
		end else if (valid_i) begin
			rsp_o <= rsp_d;
		end
	end

endmodule

`default_nettype wire

//--- hw/fault_counters.sv
/*
 * one saturating 8 bit error counter per replica
 * a CSR load wins over an increment in the same cycle
 * FAULT_THRESHOLD above 255 never raises the permanent flag
 */

`timescale 1ns/1ps
`default_nettype none

module fault_counters #(
	parameter int FAULT_THRESHOLD = 4
) (
	input  wire logic                                              clk,
	input  wire logic                                              arst_n_i,
	input  wire logic                                              valid_i,
	input  ft_cfg_pkg::replica_mask_t                              blame_i,
	input  ft_cfg_pkg::replica_mask_t                              wr_i,
	input  ft_cfg_pkg::err_cnt_t                                   wdata_i,
	output ft_cfg_pkg::err_cnt_t [ft_alu_pkg::NUM_REPLICAS-1:0]    cnt_o,
	output ft_cfg_pkg::replica_mask_t                              permanent_o
);

	ft_cfg_pkg::err_cnt_t [ft_alu_pkg::NUM_REPLICAS-1:0] cnt_q;

	for (genvar r = 0; r < ft_alu_pkg::NUM_REPLICAS; r++) begin : g_cnt

		always_ff @(posedge clk or negedge arst_n_i) begin
			if (!arst_n_i) begin
				cnt_q[r] <= '0;
			end else if (wr_i[r]) begin
				cnt_q[r] <= wdata_i;	// software load or clear
			end else if (valid_i && blame_i[r] && (cnt_q[r] != '1)) begin
				cnt_q[r] <= cnt_q[r] + 1'b1;	// stops at 255
			end
		end

		assign permanent_o[r] = (int'(cnt_q[r]) >= FAULT_THRESHOLD);

	end

	assign cnt_o = cnt_q;

endmodule

`default_nettype wire

//--- hw/ft_alu_pkg.sv
/*
 * datapath types shared by the replicas, the voter and the testbench
 * every operation completes in one cycle, no divide and no vector modes
 */

`default_nettype none

package ft_alu_pkg;

	////////////////////////////////////////////////////////////
	// replication geometry
	////////////////////////////////////////////////////////////

	localparam int NUM_REPLICAS = 4;	// three active plus one spare
	localparam int NUM_SLOTS    = 3;	// voting inputs

	typedef logic [31:0] data_t;	// operand or result word

	// integer subset kept from the core ALU
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_SLT  = 4'd8,
		ALU_SLTU = 4'd9
	} alu_op_e;

	typedef struct packed {
		alu_op_e op;
		data_t   a;
		data_t   b;
	} alu_req_t;	// 68 bits

	typedef struct packed {
		data_t result;
		logic  cmp;	// set only by slt / sltu
	} alu_rsp_t;	// 33 bits

endpackage

`default_nettype wire

//--- hw/ft_alu_top.sv
/*
 * four ALU replicas behind a configurable TMR voter
 * one cycle latency, no back-pressure, one request in flight per cycle
 */

`timescale 1ns/1ps
`default_nettype none

module ft_alu_top #(
	parameter int FAULT_THRESHOLD = 4
) (
	input  wire logic                                            clk,
	input  wire logic                                            arst_n_i,
	input  wire logic                                            op_valid_i,
	input  ft_alu_pkg::alu_req_t [ft_alu_pkg::NUM_REPLICAS-1:0]  req_i,
	output logic                                                 rsp_valid_o,
	output ft_alu_pkg::data_t                                    result_o,
	output logic                                                 cmp_o,
	output logic                                                 err_detected_o,
	output logic                                                 err_corrected_o,
	output ft_cfg_pkg::replica_mask_t                            permanent_o,
	input  wire logic                                            csr_we_i,
	input  ft_cfg_pkg::csr_addr_t                                csr_addr_i,
	input  ft_alu_pkg::data_t                                    csr_wdata_i,
	output ft_alu_pkg::data_t                                    csr_rdata_o
);

	ft_alu_pkg::alu_rsp_t [ft_alu_pkg::NUM_REPLICAS-1:0] rsp;
	ft_cfg_pkg::err_cnt_t [ft_alu_pkg::NUM_REPLICAS-1:0] cnt;
	ft_cfg_pkg::ft_cfg_t       cfg;
	ft_cfg_pkg::replica_mask_t blame;
	ft_cfg_pkg::replica_mask_t cnt_wr;
	ft_cfg_pkg::err_cnt_t      cnt_wdata;

	////////////////////////////////////////////////////////////
	// replicas
	////////////////////////////////////////////////////////////

	for (genvar r = 0; r < ft_alu_pkg::NUM_REPLICAS; r++) begin : g_rep
		alu_core i_alu_core (
			.clk      (clk),
			.arst_n_i (arst_n_i),
			.valid_i  (op_valid_i),
			.req_i    (req_i[r]),	// own copy of the request
			.rsp_o    (rsp[r])
		);
	end

	// response is valid the cycle after the strobe
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) rsp_valid_o <= 1'b0;
		else rsp_valid_o <= op_valid_i;
	end

	////////////////////////////////////////////////////////////
	// voting, error accounting, CSR
	////////////////////////////////////////////////////////////

	replica_voter i_replica_voter (
		.rsp_i           (rsp),
		.cfg_i           (cfg),
		.result_o        (result_o),
		.cmp_o           (cmp_o),
		.err_detected_o  (err_detected_o),
		.err_corrected_o (err_corrected_o),
		.blame_o         (blame)
	);

	fault_counters #(
		.FAULT_THRESHOLD (FAULT_THRESHOLD)
	) i_fault_counters (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.valid_i     (rsp_valid_o),	// blame only counts on live responses
		.blame_i     (blame),
		.wr_i        (cnt_wr),
		.wdata_i     (cnt_wdata),
		.cnt_o       (cnt),
		.permanent_o (permanent_o)
	);

	ft_csr i_ft_csr (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.csr_we_i    (csr_we_i),
		.csr_addr_i  (csr_addr_i),
		.csr_wdata_i (csr_wdata_i),
		.csr_rdata_o (csr_rdata_o),
		.cnt_i       (cnt),
		.permanent_i (permanent_o),
		.cfg_o       (cfg),
		.cnt_wr_o    (cnt_wr),
		.cnt_wdata_o (cnt_wdata)
	);

endmodule

`default_nettype wire

//--- hw/ft_cfg_pkg.sv
/*
 * fault tolerance configuration, error counter and CSR map
 * all CSR registers are 32 bits wide, unused upper bits read as zero
 */

`default_nettype none

package ft_cfg_pkg;

	////////////////////////////////////////////////////////////
	// voter configuration
	////////////////////////////////////////////////////////////

	typedef logic [2:0] slot_sel_t;	// bit k: slot k takes replica 3
	typedef logic [1:0] bypass_t;	// 0 voted, 1..3 slot 0..2 direct

	typedef struct packed {
		slot_sel_t slot_sel;	// [5:3]
		logic      only_two;	// [2]
		bypass_t   bypass;	// [1:0]
	} ft_cfg_t;

	typedef logic [2:0] slot_err_t;	// one per voting slot
	typedef logic [3:0] replica_mask_t;	// one per replica

	typedef logic [7:0] err_cnt_t;	// saturating error count

	////////////////////////////////////////////////////////////
	// CSR map
	////////////////////////////////////////////////////////////

	typedef logic [3:0] csr_addr_t;

	localparam csr_addr_t CSR_CFG    = 4'd0;
	localparam csr_addr_t CSR_CNT0   = 4'd1;
	localparam csr_addr_t CSR_CNT1   = 4'd2;
	localparam csr_addr_t CSR_CNT2   = 4'd3;
	localparam csr_addr_t CSR_CNT3   = 4'd4;
	localparam csr_addr_t CSR_STATUS = 4'd5;	// permanent fault flags in [3:0]

endpackage

`default_nettype wire

//--- hw/ft_csr.sv
/*
 * config register plus read mux over counts and status
 * reads are combinational, writes land on the next rising edge
 */

`timescale 1ns/1ps
`default_nettype none

module ft_csr (
	input  wire logic                                            clk,
	input  wire logic                                            arst_n_i,
	input  wire logic                                            csr_we_i,
	input  ft_cfg_pkg::csr_addr_t                                csr_addr_i,
	input  ft_alu_pkg::data_t                                    csr_wdata_i,
	output ft_alu_pkg::data_t                                    csr_rdata_o,
	input  ft_cfg_pkg::err_cnt_t [ft_alu_pkg::NUM_REPLICAS-1:0]  cnt_i,
	input  ft_cfg_pkg::replica_mask_t                            permanent_i,
	output ft_cfg_pkg::ft_cfg_t                                  cfg_o,
	output ft_cfg_pkg::replica_mask_t                            cnt_wr_o,
	output ft_cfg_pkg::err_cnt_t                                 cnt_wdata_o
);

	localparam int CFG_W = $bits(ft_cfg_pkg::ft_cfg_t);

	ft_cfg_pkg::ft_cfg_t cfg_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cfg_q <= '0;	// replicas 0..2, voted
		end else if (csr_we_i && (csr_addr_i == ft_cfg_pkg::CSR_CFG)) begin
			cfg_q <= csr_wdata_i[CFG_W-1:0];
		end
	end

	assign cfg_o = cfg_q;

	// counter loads go out one-hot, the counters hold the data
	always_comb begin
		cnt_wr_o = '0;
		if (csr_we_i) begin
			case (csr_addr_i)
				ft_cfg_pkg::CSR_CNT0: cnt_wr_o[0] = 1'b1;
				ft_cfg_pkg::CSR_CNT1: cnt_wr_o[1] = 1'b1;
				ft_cfg_pkg::CSR_CNT2: cnt_wr_o[2] = 1'b1;
				ft_cfg_pkg::CSR_CNT3: cnt_wr_o[3] = 1'b1;
				default: ;
			endcase
		end
	end

	assign cnt_wdata_o = csr_wdata_i[7:0];

	always_comb begin
		case (csr_addr_i)
			ft_cfg_pkg::CSR_CFG:    csr_rdata_o = {{(32-CFG_W){1'b0}}, cfg_q};
			ft_cfg_pkg::CSR_CNT0:   csr_rdata_o = {24'b0, cnt_i[0]};
			ft_cfg_pkg::CSR_CNT1:   csr_rdata_o = {24'b0, cnt_i[1]};
			ft_cfg_pkg::CSR_CNT2:   csr_rdata_o = {24'b0, cnt_i[2]};
			ft_cfg_pkg::CSR_CNT3:   csr_rdata_o = {24'b0, cnt_i[3]};
			ft_cfg_pkg::CSR_STATUS: csr_rdata_o = {28'b0, permanent_i};
			default:                csr_rdata_o = '0;	// unmapped
		endcase
	end

endmodule

`default_nettype wire

//--- hw/replica_voter.sv
/*
 * purely combinational, three of four replicas feed the vote
 * result and cmp flag are voted together as one word
 * error flags are computed even when bypass is active
 */

`timescale 1ns/1ps
`default_nettype none

module replica_voter (
	input  ft_alu_pkg::alu_rsp_t [ft_alu_pkg::NUM_REPLICAS-1:0] rsp_i,
	input  ft_cfg_pkg::ft_cfg_t                                 cfg_i,
	output ft_alu_pkg::data_t                                   result_o,
	output logic                                                cmp_o,
	output logic                                                err_detected_o,
	output logic                                                err_corrected_o,
	output ft_cfg_pkg::replica_mask_t                           blame_o
);

	ft_alu_pkg::alu_rsp_t slot [ft_alu_pkg::NUM_SLOTS];
	ft_alu_pkg::alu_rsp_t voted;
	ft_alu_pkg::alu_rsp_t sel_rsp;
	ft_cfg_pkg::slot_err_t slot_err;
	logic eq01;
	logic eq02;
	logic eq12;

	////////////////////////////////////////////////////////////
	// slot selection, spare replica replaces slot k on demand
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int k = 0; k < ft_alu_pkg::NUM_SLOTS; k++) begin
			slot[k] = cfg_i.slot_sel[k] ? rsp_i[ft_alu_pkg::NUM_REPLICAS-1] : rsp_i[k];
		end
	end

	assign eq01 = (slot[0] == slot[1]);
	assign eq02 = (slot[0] == slot[2]);
	assign eq12 = (slot[1] == slot[2]);

	////////////////////////////////////////////////////////////
	// vote or compare
	////////////////////////////////////////////////////////////

	always_comb begin
		voted           = slot[0];
		slot_err        = '0;
		err_detected_o  = 1'b0;
		err_corrected_o = 1'b0;
		if (cfg_i.only_two) begin
			// slot 2 ignored, a mismatch cannot be resolved
			if (!eq01) begin
				slot_err       = 3'b011;
				err_detected_o = 1'b1;
			end
		end else if (eq01 && eq02) begin
			voted = slot[0];	// full agreement
		end else if (eq01 || eq02 || eq12) begin
			err_detected_o  = 1'b1;
			err_corrected_o = 1'b1;
			if (eq01) begin
				slot_err = 3'b100;
			end else if (eq02) begin
				slot_err = 3'b010;
			end else begin
				slot_err = 3'b001;
				voted    = slot[1];	// slot 0 is the odd one
			end
		end else begin
			slot_err       = 3'b111;	// no majority, slot 0 passes through
			err_detected_o = 1'b1;
		end
	end

	// bypass picks one slot directly
	always_comb begin
		case (cfg_i.bypass)
			2'd1:    sel_rsp = slot[0];
			2'd2:    sel_rsp = slot[1];
			2'd3:    sel_rsp = slot[2];
			default: sel_rsp = voted;
		endcase
	end

	assign result_o = sel_rsp.result;
	assign cmp_o    = sel_rsp.cmp;

	// map flagged slots back onto the physical replicas
	always_comb begin
		blame_o = '0;
		for (int k = 0; k < ft_alu_pkg::NUM_SLOTS; k++) begin
			if (slot_err[k]) begin
				if (cfg_i.slot_sel[k]) blame_o[ft_alu_pkg::NUM_REPLICAS-1] = 1'b1;
				else blame_o[k] = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
hw/ft_alu_pkg.sv
hw/ft_cfg_pkg.sv
hw/alu_core.sv
hw/replica_voter.sv
hw/fault_counters.sv
hw/ft_csr.sv
hw/ft_alu_top.sv
dv/tb_ft_alu.sv
